// File: hdl/id_params.svh
`ifndef ID_PARAMS_SVH
`define ID_PARAMS_SVH

`define ID_XLEN 32

// rv32i major opcodes, instr[6:0]
`define ID_OPC_LUI     7'b0110111
`define ID_OPC_AUIPC   7'b0010111
`define ID_OPC_JAL     7'b1101111
`define ID_OPC_JALR    7'b1100111
`define ID_OPC_BRANCH  7'b1100011
`define ID_OPC_LOAD    7'b0000011
`define ID_OPC_STORE   7'b0100011
`define ID_OPC_OPIMM   7'b0010011
`define ID_OPC_OP      7'b0110011
`define ID_OPC_MISC    7'b0001111
`define ID_OPC_SYSTEM  7'b1110011

// funct3 values that steer the misc and system groups
`define ID_F3_PRIV     3'b000
`define ID_F3_FENCEI   3'b001

// instr[31:20] of a privileged system instruction
`define ID_SYS_ECALL   12'h000
`define ID_SYS_EBREAK  12'h001
`define ID_SYS_MRET    12'h302

`define ID_ALU_NONE    4'd0
`define ID_ALU_LUI     4'd1
`define ID_ALU_AUIPC   4'd2
`define ID_ALU_JAL     4'd3
`define ID_ALU_JALR    4'd4
`define ID_ALU_BR      4'd5
`define ID_ALU_LS      4'd6
`define ID_ALU_OP      4'd7
`define ID_ALU_SYS     4'd8
`define ID_ALU_CSR     4'd9

`define ID_MASK_B      4'b0001
`define ID_MASK_H      4'b0011
`define ID_MASK_W      4'b1111

`endif

// File: hdl/id_pkg.sv
`default_nettype none
`include "id_params.svh"

package id_pkg;

  // rv32i instruction formats, msb first
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;   // also the csr address / system code
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // one word, six views
  typedef union packed {
    logic [`ID_XLEN-1:0] raw;
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } instr_word_u;

  typedef enum logic [3:0] {
    cls_lui, cls_auipc, cls_jal, cls_jalr, cls_branch, cls_load, cls_store,
    cls_opimm, cls_op, cls_misc,
    cls_csr,   // system, funct3 != 0
    cls_priv,  // ecall / ebreak / mret
    cls_illegal
  } op_class_e;

  typedef struct packed {
    logic [`ID_XLEN-1:0] pc;
    instr_word_u         instr;
    op_class_e           op_class;
  } capture_t;

  typedef struct packed {
    logic alu_en;
    logic adder_en;
  } exe_flags_t;

  typedef struct packed {
    logic csr_wr_en;
    logic mem_rd_en;
    logic mem_wr_en;
    logic branch_en;
  } mem_flags_t;

  typedef struct packed {
    logic       rs1_en;
    logic       rs2_en;
    logic       rd_en;          // write-back flag
    exe_flags_t exe;
    mem_flags_t mem;
    logic       alu_src;        // 1 selects imm
    logic [3:0] alu_op;
    logic       mem_to_reg;
    logic [3:0] mem_mask;
    logic       load_unsigned;
    logic       csr_rd_en;
    logic       ecall;
    logic       ebreak;
    logic       mret;
    logic       flush;          // fence.i
    logic [1:0] stage_cnt;      // later stages needed
  } ctrl_t;

  typedef struct packed {
    logic [`ID_XLEN-1:0] pc;
    logic [`ID_XLEN-1:0] imm;
    logic [3:0]          funct4;  // {instr[30], funct3}
    logic [4:0]          rd_addr;
    logic [4:0]          rs1_addr;
    logic [4:0]          rs2_addr;
    logic [11:0]         csr_addr;
    ctrl_t               ctrl;
  } id_bundle_t;

endpackage

`default_nettype wire

// File: hdl/instr_capture.sv
`timescale 1ns/1ps
`default_nettype none
`include "id_params.svh"

module instr_capture (
  input  logic                clk,
  input  logic                reset,
  input  logic                in_valid,
  output logic                in_ready,
  input  logic [`ID_XLEN-1:0] in_pc,
  input  logic [`ID_XLEN-1:0] in_instr,
  output id_pkg::capture_t    cap,
  output logic                cap_valid,
  input  logic                cap_ready
);

  id_pkg::instr_word_u in_word;

  // opcode + funct3 -> one class for everything downstream
  function automatic id_pkg::op_class_e classify(input id_pkg::instr_word_u iw);
    case (iw.r.opcode)
      `ID_OPC_LUI:    classify = id_pkg::cls_lui;
      `ID_OPC_AUIPC:  classify = id_pkg::cls_auipc;
      `ID_OPC_JAL:    classify = id_pkg::cls_jal;
      `ID_OPC_JALR:   classify = id_pkg::cls_jalr;
      `ID_OPC_BRANCH: classify = id_pkg::cls_branch;
      `ID_OPC_LOAD:   classify = id_pkg::cls_load;
      `ID_OPC_STORE:  classify = id_pkg::cls_store;
      `ID_OPC_OPIMM:  classify = id_pkg::cls_opimm;
      `ID_OPC_OP:     classify = id_pkg::cls_op;
      `ID_OPC_MISC:   classify = id_pkg::cls_misc;
      `ID_OPC_SYSTEM: classify = (iw.r.funct3 == `ID_F3_PRIV) ? id_pkg::cls_priv
                                                             : id_pkg::cls_csr;
      default:        classify = id_pkg::cls_illegal;
    endcase
  endfunction

  assign in_word.raw = in_instr;
  assign in_ready = ~cap_valid | cap_ready;  // empty, or draining this cycle

  always_ff @(posedge clk) begin
    if (reset) begin
      cap_valid <= 1'b0;
    end else if (in_ready) begin
      cap_valid <= in_valid;
    end
  end

  // payload only moves on a transfer
  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      cap.pc       <= in_pc;
      cap.instr    <= in_word;
      cap.op_class <= classify(in_word);
    end
  end

endmodule

`default_nettype wire

// File: hdl/control_decode.sv
`timescale 1ns/1ps
`default_nettype none
`include "id_params.svh"

module control_decode (
  input  id_pkg::capture_t cap,
  output id_pkg::ctrl_t    ctrl
);

  logic [2:0]  funct3;
  logic        rd_nz;     // rd field nonzero
  logic        rs1_nz;    // rs1 field (or uimm) nonzero
  logic [11:0] sys_code;

  assign funct3   = cap.instr.i.funct3;
  assign rd_nz    = |cap.instr.i.rd;
  assign rs1_nz   = |cap.instr.i.rs1;
  assign sys_code = cap.instr.i.imm;

  // funct3[1:0] -> byte lanes, 3 is not a valid width
  function automatic logic [3:0] mask_of(input logic [1:0] width);
    case (width)
      2'd0:    mask_of = `ID_MASK_B;
      2'd1:    mask_of = `ID_MASK_H;
      2'd2:    mask_of = `ID_MASK_W;
      default: mask_of = 4'b0000;
    endcase
  endfunction

  always_comb begin
    ctrl = '0;  // misc / priv / illegal stay mostly zero
    case (cap.op_class)
      id_pkg::cls_lui: begin
        ctrl.exe.adder_en = 1'b1;
        ctrl.alu_src      = 1'b1;
        ctrl.alu_op       = `ID_ALU_LUI;
        ctrl.rd_en        = 1'b1;
        ctrl.stage_cnt    = 2'd3;
      end
      id_pkg::cls_auipc: begin
        ctrl.exe.adder_en = 1'b1;
        ctrl.alu_src      = 1'b1;
        ctrl.alu_op       = `ID_ALU_AUIPC;
        ctrl.rd_en        = 1'b1;
        ctrl.stage_cnt    = 2'd3;
      end
      id_pkg::cls_jal, id_pkg::cls_jalr: begin
        ctrl.rs1_en        = (cap.op_class == id_pkg::cls_jalr);  // jal has no rs1
        ctrl.exe           = '{alu_en: 1'b1, adder_en: 1'b1};
        ctrl.mem.branch_en = 1'b1;
        ctrl.alu_src       = 1'b1;
        ctrl.alu_op        = (cap.op_class == id_pkg::cls_jal) ? `ID_ALU_JAL : `ID_ALU_JALR;
        ctrl.rd_en         = 1'b1;  // link register
        ctrl.stage_cnt     = 2'd3;
      end
      id_pkg::cls_branch: begin
        ctrl.rs1_en        = 1'b1;
        ctrl.rs2_en        = 1'b1;
        ctrl.exe           = '{alu_en: 1'b1, adder_en: 1'b1};  // compare + target
        ctrl.mem.branch_en = 1'b1;
        ctrl.alu_op        = `ID_ALU_BR;
        ctrl.stage_cnt     = 2'd2;
      end
      id_pkg::cls_load: begin
        ctrl.rs1_en        = 1'b1;
        ctrl.exe.alu_en    = 1'b1;  // address add
        ctrl.mem.mem_rd_en = 1'b1;
        ctrl.alu_src       = 1'b1;
        ctrl.alu_op        = `ID_ALU_LS;
        ctrl.mem_to_reg    = 1'b1;
        ctrl.mem_mask      = mask_of(funct3[1:0]);
        ctrl.load_unsigned = funct3[2];  // lbu / lhu
        ctrl.rd_en         = 1'b1;
        ctrl.stage_cnt     = 2'd3;
      end
      id_pkg::cls_store: begin
        ctrl.rs1_en        = 1'b1;
        ctrl.rs2_en        = 1'b1;
        ctrl.exe.alu_en    = 1'b1;
        ctrl.mem.mem_wr_en = 1'b1;
        ctrl.alu_src       = 1'b1;
        ctrl.alu_op        = `ID_ALU_LS;
        ctrl.mem_mask      = mask_of(funct3[1:0]);
        ctrl.stage_cnt     = 2'd2;  // no write-back
      end
      id_pkg::cls_opimm, id_pkg::cls_op: begin
        ctrl.rs1_en     = 1'b1;
        ctrl.rs2_en     = (cap.op_class == id_pkg::cls_op);
        ctrl.exe.alu_en = 1'b1;
        ctrl.alu_src    = (cap.op_class == id_pkg::cls_opimm);
        ctrl.alu_op     = `ID_ALU_OP;
        ctrl.rd_en      = 1'b1;
        ctrl.stage_cnt  = 2'd3;
      end
      id_pkg::cls_csr: begin
        ctrl.rs1_en        = 1'b1;
        ctrl.exe.alu_en    = 1'b1;
        ctrl.alu_src       = funct3[2];  // csrr*i takes uimm
        ctrl.alu_op        = `ID_ALU_CSR;
        // csrrw with rd=x0 does not read the csr
        ctrl.csr_rd_en     = funct3[1] | rd_nz;
        // csrrs/csrrc with rs1=x0 only read it
        ctrl.mem.csr_wr_en = ~funct3[1] | rs1_nz;
        ctrl.rd_en         = funct3[1] | rd_nz;
        ctrl.stage_cnt     = (funct3[1] | rd_nz) ? 2'd3 : 2'd2;
      end
      id_pkg::cls_priv: begin
        ctrl.alu_op = `ID_ALU_SYS;
        ctrl.ecall  = (sys_code == `ID_SYS_ECALL);
        ctrl.ebreak = (sys_code == `ID_SYS_EBREAK);
        ctrl.mret   = (sys_code == `ID_SYS_MRET);
      end
      id_pkg::cls_misc: begin
        ctrl.alu_op = `ID_ALU_NONE;
        ctrl.flush  = (funct3 == `ID_F3_FENCEI);  // plain fence is a no-op here
      end
      default: begin
        ctrl.alu_op = `ID_ALU_NONE;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/imm_gen.sv
`timescale 1ns/1ps
`default_nettype none
`include "id_params.svh"

module imm_gen (
  input  id_pkg::capture_t    cap,
  output logic [`ID_XLEN-1:0] imm
);

  id_pkg::instr_word_u iw;
  logic                sign;  // instr[31], same bit in every view

  assign iw   = cap.instr;
  assign sign = iw.raw[`ID_XLEN-1];

  always_comb begin
    case (cap.op_class)
      id_pkg::cls_lui, id_pkg::cls_auipc: begin
        imm = {iw.u.imm_31_12, 12'b0};
      end
      id_pkg::cls_jal: begin
        imm = {{(`ID_XLEN-20){sign}}, iw.j.imm_19_12, iw.j.imm_11, iw.j.imm_10_1, 1'b0};
      end
      id_pkg::cls_jalr, id_pkg::cls_load: begin
        imm = {{(`ID_XLEN-12){sign}}, iw.i.imm};
      end
      id_pkg::cls_opimm: begin
        if (iw.i.funct3[1:0] == 2'b01) begin
          imm = {{(`ID_XLEN-5){1'b0}}, iw.r.rs2};  // slli/srli/srai shamt
        end else begin
          imm = {{(`ID_XLEN-12){sign}}, iw.i.imm};
        end
      end
      id_pkg::cls_branch: begin
        imm = {{(`ID_XLEN-12){sign}}, iw.b.imm_11, iw.b.imm_10_5, iw.b.imm_4_1, 1'b0};
      end
      id_pkg::cls_store: begin
        imm = {{(`ID_XLEN-12){sign}}, iw.s.imm_11_5, iw.s.imm_4_0};
      end
      id_pkg::cls_csr: begin
        // uimm sits in the rs1 slot
        imm = iw.i.funct3[2] ? {{(`ID_XLEN-5){1'b0}}, iw.i.rs1} : '0;
      end
      default: begin
        imm = '0;  // op, misc, priv, illegal
      end
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/bundle_reg.sv
`timescale 1ns/1ps
`default_nettype none
`include "id_params.svh"

module bundle_reg (
  input  logic                clk,
  input  logic                reset,
  input  id_pkg::capture_t    cap,
  input  logic                cap_valid,
  output logic                cap_ready,
  input  id_pkg::ctrl_t       ctrl,
  input  logic [`ID_XLEN-1:0] imm,
  output logic                out_valid,
  input  logic                out_ready,
  output id_pkg::id_bundle_t  out_bundle
);

  id_pkg::id_bundle_t next_bundle;

  // take a new item when empty or when the current one leaves
  assign cap_ready = ~out_valid | out_ready;

  always_comb begin
    next_bundle.pc       = cap.pc;
    next_bundle.imm      = imm;
    next_bundle.funct4   = {cap.instr.r.funct7[5], cap.instr.r.funct3};  // sub/sra bit
    next_bundle.rd_addr  = cap.instr.r.rd;
    next_bundle.rs1_addr = cap.instr.r.rs1;
    next_bundle.rs2_addr = cap.instr.r.rs2;
    next_bundle.csr_addr = cap.instr.i.imm;
    next_bundle.ctrl     = ctrl;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (cap_ready) begin
      out_valid <= cap_valid;
    end
  end

  // held while out_ready is low
  always_ff @(posedge clk) begin
    if (cap_valid && cap_ready) begin
      out_bundle <= next_bundle;
    end
  end

endmodule

`default_nettype wire

// File: hdl/id_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "id_params.svh"

module id_stage (
  input  logic                clk,
  input  logic                reset,
  input  logic                in_valid,
  output logic                in_ready,
  input  logic [`ID_XLEN-1:0] in_pc,
  input  logic [`ID_XLEN-1:0] in_instr,
  output logic                out_valid,
  input  logic                out_ready,
  output id_pkg::id_bundle_t  out_bundle
);

  id_pkg::capture_t    cap;        // first register
  logic                cap_valid;
  logic                cap_ready;  // back-pressure from the output side
  id_pkg::ctrl_t       ctrl;
  logic [`ID_XLEN-1:0] imm;

  instr_capture u_instr_capture (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_pc     (in_pc),
    .in_instr  (in_instr),
    .cap       (cap),
    .cap_valid (cap_valid),
    .cap_ready (cap_ready)
  );

  // decode is combinational between the two registers
  control_decode u_control_decode (
    .cap  (cap),
    .ctrl (ctrl)
  );

  imm_gen u_imm_gen (
    .cap (cap),
    .imm (imm)
  );

  bundle_reg u_bundle_reg (
    .clk        (clk),
    .reset      (reset),
    .cap        (cap),
    .cap_valid  (cap_valid),
    .cap_ready  (cap_ready),
    .ctrl       (ctrl),
    .imm        (imm),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_bundle (out_bundle)
  );

endmodule

`default_nettype wire

// File: test/id_vectors.svh
`ifndef ID_VECTORS_SVH
`define ID_VECTORS_SVH

localparam int NUM_VECS = 24;

// columns: pc, instruction, expected imm, expected ctrl_t
// ctrl_t bits, msb first
//   rs1/rs2/rd_en _ alu/adder _ csr_wr/mem_rd/mem_wr/branch _ alu_src _ alu_op _
//   mem_to_reg _ mem_mask _ load_unsigned _ csr_rd_en _ ecall/ebreak/mret/flush _ stage_cnt
localparam vec_t VECS [NUM_VECS] = '{
  '{32'h100, 32'h123452b7, 32'h12345000, 27'b001_01_0000_1_0001_0_0000_0_0_0000_11}, // lui
  '{32'h104, 32'hfffff317, 32'hfffff000, 27'b001_01_0000_1_0010_0_0000_0_0_0000_11}, // auipc
  '{32'h108, 32'h344120ef, 32'h00012344, 27'b001_11_0001_1_0011_0_0000_0_0_0000_11}, // jal
  '{32'h10c, 32'hffc100e7, 32'hfffffffc, 27'b101_11_0001_1_0100_0_0000_0_0_0000_11}, // jalr
  '{32'h110, 32'hfe4188e3, 32'hfffffff0, 27'b110_11_0001_0_0101_0_0000_0_0_0000_10}, // beq -16
  '{32'h114, 32'h01040383, 32'h00000010, 27'b101_10_0100_1_0110_1_0001_0_0_0000_11}, // lb
  '{32'h118, 32'hffe55483, 32'hfffffffe, 27'b101_10_0100_1_0110_1_0011_1_0_0000_11}, // lhu
  '{32'h11c, 32'h7ff62583, 32'h000007ff, 27'b101_10_0100_1_0110_1_1111_0_0_0000_11}, // lw
  '{32'h120, 32'h00104683, 32'h00000001, 27'b101_10_0100_1_0110_1_0001_1_0_0000_11}, // lbu
  '{32'h124, 32'hfee78fa3, 32'hffffffff, 27'b110_10_0010_1_0110_0_0001_0_0_0000_10}, // sb
  '{32'h128, 32'h03089123, 32'h00000022, 27'b110_10_0010_1_0110_0_0011_0_0_0000_10}, // sh
  '{32'h12c, 32'h1129a023, 32'h00000100, 27'b110_10_0010_1_0110_0_1111_0_0_0000_10}, // sw
  '{32'h130, 32'hf9ca8a13, 32'hffffff9c, 27'b101_10_0000_1_0111_0_0000_0_0_0000_11}, // addi
  '{32'h134, 32'h41fbdb13, 32'h0000001f, 27'b101_10_0000_1_0111_0_0000_0_0_0000_11}, // srai
  '{32'h138, 32'h41ac8c33, 32'h00000000, 27'b111_10_0000_0_0111_0_0000_0_0_0000_11}, // sub
  '{32'h13c, 32'h0ff0000f, 32'h00000000, 27'b000_00_0000_0_0000_0_0000_0_0_0000_00}, // fence
  '{32'h140, 32'h0000100f, 32'h00000000, 27'b000_00_0000_0_0000_0_0000_0_0_0001_00}, // fence.i
  '{32'h144, 32'h00000073, 32'h00000000, 27'b000_00_0000_0_1000_0_0000_0_0_1000_00}, // ecall
  '{32'h148, 32'h00100073, 32'h00000000, 27'b000_00_0000_0_1000_0_0000_0_0_0100_00}, // ebreak
  '{32'h14c, 32'h30200073, 32'h00000000, 27'b000_00_0000_0_1000_0_0000_0_0_0010_00}, // mret
  '{32'h150, 32'h30029073, 32'h00000000, 27'b100_10_1000_0_1001_0_0000_0_0_0000_10}, // csrrw x0
  '{32'h154, 32'h34202573, 32'h00000000, 27'b101_10_0000_0_1001_0_0000_0_1_0000_11}, // csrrs rs1=x0
  '{32'h158, 32'h305fd373, 32'h0000001f, 27'b101_10_1000_1_1001_0_0000_0_1_0000_11}, // csrrwi
  '{32'h15c, 32'hffffffff, 32'h00000000, 27'b000_00_0000_0_0000_0_0000_0_0_0000_00}  // illegal
};

`endif

// File: test/id_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "id_params.svh"

module id_stage_tb;

  // one table row
  typedef struct packed {
    logic [`ID_XLEN-1:0] pc;
    logic [`ID_XLEN-1:0] instr;
    logic [`ID_XLEN-1:0] imm;   // expected
    id_pkg::ctrl_t       ctrl;  // expected
  } vec_t;

  `include "id_vectors.svh"

  localparam int MAX_CYCLES = 16 + 8 * NUM_VECS + 50;

  logic                clk = 1'b0;
  logic                reset = 1'b1;
  logic                in_valid = 1'b0;
  logic                in_ready;
  logic [`ID_XLEN-1:0] in_pc = '0;
  logic [`ID_XLEN-1:0] in_instr = '0;
  logic                out_valid;
  logic                out_ready = 1'b0;
  id_pkg::id_bundle_t  out_bundle;

  int          rx_count = 0;  // scoreboard pointer
  int          tx_count = 0;  // input transfers so far
  int          passed = 0;
  int          failed = 0;
  int          errors = 0;
  int          cycles = 0;
  logic        entry_bad;

  id_stage u_id_stage (
    .clk        (clk),
    .reset      (reset),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .in_pc      (in_pc),
    .in_instr   (in_instr),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_bundle (out_bundle)
  );

  always #5 clk = ~clk;

  // sink stalls on roughly 40% of cycles
  always @(posedge clk) begin
    out_ready <= ($urandom_range(99) < 60);
  end

  task automatic check_field(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    assert (act_val === exp_val) else begin
      $display("ERR %s expected %h actual %h", name, exp_val, act_val);
      errors++;
      entry_bad = 1'b1;
    end
  endtask

  task automatic compare_bundle(input int idx, input id_pkg::id_bundle_t act);
    vec_t        v;
    logic [31:0] iw;
    v  = VECS[idx];
    iw = v.instr;
    entry_bad = 1'b0;
    check_field("pc", v.pc, act.pc);
    check_field("imm", v.imm, act.imm);
    // addresses sit at fixed rv32i bit positions
    check_field("funct4", 32'({iw[30], iw[14:12]}), 32'(act.funct4));
    check_field("rd_addr", 32'(iw[11:7]), 32'(act.rd_addr));
    check_field("rs1_addr", 32'(iw[19:15]), 32'(act.rs1_addr));
    check_field("rs2_addr", 32'(iw[24:20]), 32'(act.rs2_addr));
    check_field("csr_addr", 32'(iw[31:20]), 32'(act.csr_addr));
    check_field("reg_en", 32'({v.ctrl.rs1_en, v.ctrl.rs2_en, v.ctrl.rd_en}),
                32'({act.ctrl.rs1_en, act.ctrl.rs2_en, act.ctrl.rd_en}));
    check_field("exe_flags", 32'(v.ctrl.exe), 32'(act.ctrl.exe));
    check_field("mem_flags", 32'(v.ctrl.mem), 32'(act.ctrl.mem));
    check_field("alu_src", 32'(v.ctrl.alu_src), 32'(act.ctrl.alu_src));
    check_field("alu_op", 32'(v.ctrl.alu_op), 32'(act.ctrl.alu_op));
    check_field("mem_to_reg", 32'(v.ctrl.mem_to_reg), 32'(act.ctrl.mem_to_reg));
    check_field("mem_mask", 32'(v.ctrl.mem_mask), 32'(act.ctrl.mem_mask));
    check_field("load_unsigned", 32'(v.ctrl.load_unsigned), 32'(act.ctrl.load_unsigned));
    check_field("csr_rd_en", 32'(v.ctrl.csr_rd_en), 32'(act.ctrl.csr_rd_en));
    check_field("sys_strobes", 32'({v.ctrl.ecall, v.ctrl.ebreak, v.ctrl.mret, v.ctrl.flush}),
                32'({act.ctrl.ecall, act.ctrl.ebreak, act.ctrl.mret, act.ctrl.flush}));
    check_field("stage_cnt", 32'(v.ctrl.stage_cnt), 32'(act.ctrl.stage_cnt));
  endtask

  // hold the item until in_ready is seen mid-cycle
  task automatic wait_accept();
    logic taken;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = in_ready;
      @(posedge clk);
    end
  endtask

  // monitor samples at negedge, away from the driving edge
  always @(negedge clk) begin
    if (reset) begin
      assert (!out_valid) else begin
        $display("out_valid went high during reset");
        errors++;
      end
    end else begin
      if (tx_count == 0) begin
        assert (!out_valid && in_ready) else begin
          $display("stage not idle after reset, out_valid %b in_ready %b", out_valid, in_ready);
          errors++;
        end
      end
      // in_ready drops only with two items held and the sink stalled
      assert (in_ready === ((tx_count - rx_count) < 2 || out_ready)) else begin
        $display("in_ready %b with %0d items in flight and out_ready %b",
                 in_ready, tx_count - rx_count, out_ready);
        errors++;
      end
      if (in_valid && in_ready) begin
        tx_count++;
      end
      if (out_valid && out_ready) begin
        if (rx_count < NUM_VECS) begin
          compare_bundle(rx_count, out_bundle);
          if (entry_bad) begin
            failed++;
          end else begin
            passed++;
          end
          $display("entry %0d pc %h instr %h %s", rx_count, VECS[rx_count].pc,
                   VECS[rx_count].instr, entry_bad ? "mismatch" : "ok");
          rx_count++;
        end else begin
          $display("extra output beyond the table, pc %h", out_bundle.pc);
          errors++;
        end
      end
    end
  end

  // watchdog
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("run timed out after %0d cycles with %0d of %0d entries received",
               cycles, rx_count, NUM_VECS);
      $display("TESTS FAILED");
      $finish;
    end
  end

  initial begin
    void'($urandom(58476));
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);
    for (int i = 0; i < NUM_VECS; i++) begin
      if ($urandom_range(4) == 0) begin
        in_valid <= 1'b0;  // source bubble
        @(posedge clk);
      end
      in_valid <= 1'b1;
      in_pc    <= VECS[i].pc;
      in_instr <= VECS[i].instr;
      wait_accept();
    end
    in_valid <= 1'b0;
    wait (rx_count == NUM_VECS);
    repeat (4) @(posedge clk);  // room for stray outputs
    $display("%0d entries, %0d matched, %0d mismatched, %0d errors",
             NUM_VECS, passed, failed, errors);
    if (errors == 0 && passed == NUM_VECS) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
+incdir+hdl
+incdir+test
hdl/id_pkg.sv
hdl/instr_capture.sv
hdl/control_decode.sv
hdl/imm_gen.sv
hdl/bundle_reg.sv
hdl/id_stage.sv
test/id_stage_tb.sv

// File: Makefile
TOP       ?= id_stage_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
SEED      ?= 58476
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard hdl/*.sv hdl/*.svh test/*.sv test/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) +verilator+seed+$(SEED) | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "TESTS PASSED" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
